// ==== verilog/ht_pkg.sv ====
`default_nettype none

// ======================================================================
// Shared widths and types for the hashed page table core
// ======================================================================

package ht_pkg;

	// Virtual address and address space id widths
	localparam int vadr_w = 32;
	localparam int asid_w = 10;

	// Pages are 4 KiB so the page number is the top 20 bits of vadr
	localparam int vpn_w = 20;
	localparam int ppn_w = 20;

	// Page group index and bounce counter widths
	localparam int group_w = 10;
	localparam int bounce_w = 8;

	// Eight entries make up one page group
	localparam int slots = 8;
	localparam int pte_w = 64;

	// Decoded view of one page table entry, most significant field first
	typedef struct packed {
		logic [12:0] rsvd;
		logic valid;
		logic [asid_w-1:0] asid;
		logic [vpn_w-1:0] vpn;
		logic [ppn_w-1:0] ppn;
	} ht_pte_fields_t;

	// The load port writes the raw word while the walker reads fields
	typedef union packed {
		logic [pte_w-1:0] raw;
		ht_pte_fields_t f;
	} ht_pte_u;

	// ==================================================================
	// Address to group hash
	// ==================================================================

	// Folds the two halves of the page number together and mixes in
	// the address space so equal pages of different spaces spread out
	function automatic logic [group_w-1:0] ht_hash_fn(
		input logic [vadr_w-1:0] vadr,
		input logic [asid_w-1:0] asid
	);
		logic [vpn_w-1:0] vpn;
		vpn = vadr[vadr_w-1:vadr_w-vpn_w];
		return vpn[9:0] ^ vpn[19:10] ^ asid;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/ht_hash.sv ====
`timescale 1ns/1ps
`default_nettype none

// ======================================================================
// Home group and probe group generation
// ======================================================================

module ht_hash #(
	parameter int unsigned groups_log2 = ht_pkg::group_w
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [ht_pkg::vadr_w-1:0] vadr,
	input wire logic [ht_pkg::asid_w-1:0] asid,
	input wire logic [ht_pkg::bounce_w-1:0] bounce,
	input wire logic probe_valid,
	output logic [ht_pkg::group_w-1:0] home_group,
	output logic [ht_pkg::group_w-1:0] probe_group
);
	import ht_pkg::*;

	// Keeps every index inside the table that is actually built
	localparam logic [group_w-1:0] grp_mask = group_w'((1 << groups_log2) - 1);

	// Group used by the previous probe, needed once probing turns linear
	logic [group_w-1:0] prev_group;
	logic [group_w-1:0] bounce_sq;
	logic linear;

	always_comb begin
		home_group = ht_hash_fn(vadr, asid) & grp_mask;
		// Square only matters below 32, so ten bits are plenty
		bounce_sq = group_w'(bounce) * group_w'(bounce);
		// Quadratic steps stop at bounce 32
		linear = |bounce[bounce_w-1:5];
		if (bounce == '0)
			probe_group = home_group;
		else if (!linear)
			probe_group = (home_group + bounce_sq + group_w'(1)) & grp_mask;
		else
			probe_group = (prev_group + group_w'(1)) & grp_mask;
	end

	// Tracks the group the walker really addressed, so the linear
	// phase continues from the last quadratic probe
	always_ff @(posedge clk) begin
		if (rst)
			prev_group <= '0;
		else if (probe_valid)
			prev_group <= probe_group;
	end

endmodule

`default_nettype wire

// ==== verilog/ht_group_table.sv ====
`timescale 1ns/1ps
`default_nettype none

// ======================================================================
// Page group storage
// ======================================================================

module ht_group_table #(
	parameter int unsigned groups_log2 = ht_pkg::group_w
) (
	input wire logic clk,
	input wire logic wr_en,
	input wire logic [ht_pkg::group_w-1:0] wr_group,
	input wire logic [2:0] wr_slot,
	input wire ht_pkg::ht_pte_u wr_data,
	input wire logic [ht_pkg::group_w-1:0] rd_group_idx,
	output logic [ht_pkg::slots*ht_pkg::pte_w-1:0] rd_group
);
	import ht_pkg::*;

	localparam int depth = 1 << groups_log2;

	// Only the low groups_log2 bits of each index select a row
	logic [groups_log2-1:0] wr_row;
	logic [groups_log2-1:0] rd_row;

	assign wr_row = wr_group[groups_log2-1:0];
	assign rd_row = rd_group_idx[groups_log2-1:0];

	// ==================================================================
	// One memory per slot
	// ==================================================================

	// Splitting the group across eight narrow memories lets a single
	// read return all eight entries of a group at once
	for (genvar s = 0; s < slots; s++) begin : g_slot
		logic [pte_w-1:0] mem [depth];
		logic sel;

		// This slot takes the write when the load addresses it
		assign sel = wr_en && (wr_slot == 3'(s));

		always_ff @(posedge clk) begin
			if (sel)
				mem[wr_row] <= wr_data.raw;
		end

		// Registered read, data appears one cycle after the address
		always_ff @(posedge clk) begin
			rd_group[s*pte_w +: pte_w] <= mem[rd_row];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ht_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

// ======================================================================
// Translation walker with req/ack handshake
// ======================================================================

module ht_walker #(
	parameter int unsigned max_bounce = 40
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire logic [ht_pkg::vadr_w-1:0] vadr,
	input wire logic [ht_pkg::asid_w-1:0] asid,
	output logic ack,
	output logic hit,
	output logic [ht_pkg::ppn_w-1:0] ppn,
	output logic [ht_pkg::bounce_w-1:0] bounce,
	output logic probe_valid,
	output logic [ht_pkg::vadr_w-1:0] lat_vadr,
	output logic [ht_pkg::asid_w-1:0] lat_asid,
	input wire logic [ht_pkg::slots*ht_pkg::pte_w-1:0] rd_group
);
	import ht_pkg::*;

	localparam int slot_w = $clog2(slots);

	// Walker states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_cmp = 2'd2;
	localparam logic [1:0] st_done = 2'd3;

	logic [1:0] state;
	ht_pte_u ent [slots];
	logic [ppn_w-1:0] slot_ppn [slots];
	logic [slots-1:0] match;
	logic [slots-1:0] empty;
	logic found;
	logic [slot_w-1:0] hit_slot;
	logic bounce_limit;
	logic accept;

	// A new request is only taken while the previous ack is gone
	assign accept = (state == st_idle) && req && !ack;

	// The hash unit registers the group address during this state
	assign probe_valid = (state == st_addr);

	assign bounce_limit = (bounce >= bounce_w'(max_bounce));

	// ==================================================================
	// Parallel compare of the eight entries
	// ==================================================================

	always_comb begin
		for (int i = 0; i < slots; i++) begin
			ent[i].raw = rd_group[i*pte_w +: pte_w];
			slot_ppn[i] = ent[i].f.ppn;
			// A match needs a valid entry of the same space and page
			match[i] = ent[i].f.valid && (ent[i].f.asid == lat_asid) &&
				(ent[i].f.vpn == lat_vadr[vadr_w-1:vadr_w-vpn_w]);
			empty[i] = !ent[i].f.valid;
		end
	end

	// Lowest matching slot wins, so scan from the top down
	always_comb begin
		found = |match;
		hit_slot = '0;
		for (int i = slots - 1; i >= 0; i--) begin
			if (match[i])
				hit_slot = slot_w'(i);
		end
	end

	// Request is held here so the hash and compare see stable values
	always_ff @(posedge clk) begin
		if (accept) begin
			lat_vadr <= vadr;
			lat_asid <= asid;
		end
	end

	// ==================================================================
	// Control FSM
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ack <= 1'b0;
			hit <= 1'b0;
			ppn <= '0;
			bounce <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						bounce <= '0;
						state <= st_addr;
					end
				end
				// Group address goes to the table this cycle
				st_addr: state <= st_cmp;
				st_cmp: begin
					if (found) begin
						hit <= 1'b1;
						ppn <= slot_ppn[hit_slot];
						state <= st_done;
					end else if ((|empty) || bounce_limit) begin
						// Free slot means the page was never loaded
						hit <= 1'b0;
						ppn <= '0;
						state <= st_done;
					end else begin
						// Full group and no match, try the next group
						bounce <= bounce + bounce_w'(1);
						state <= st_addr;
					end
				end
				st_done: begin
					// Result is final, hold ack until req is released
					if (!ack)
						ack <= 1'b1;
					else if (!req) begin
						ack <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ht_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// ======================================================================
// Hashed page table translation core
// ======================================================================

module ht_top #(
	parameter int unsigned max_bounce = 40,
	parameter int unsigned groups_log2 = ht_pkg::group_w
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire logic [ht_pkg::vadr_w-1:0] vadr,
	input wire logic [ht_pkg::asid_w-1:0] asid,
	output logic ack,
	output logic hit,
	output logic [ht_pkg::ppn_w-1:0] ppn,
	input wire logic wr_en,
	input wire logic [ht_pkg::group_w-1:0] wr_group,
	input wire logic [2:0] wr_slot,
	input wire ht_pkg::ht_pte_u wr_data
);
	import ht_pkg::*;

	logic [bounce_w-1:0] bounce;
	logic probe_valid;
	logic [group_w-1:0] probe_group;
	logic [slots*pte_w-1:0] rd_group;
	logic [vadr_w-1:0] lat_vadr;
	logic [asid_w-1:0] lat_asid;

	// Hash runs on the latched request, not the raw inputs
	ht_hash #(
		.groups_log2(groups_log2)
	) u_hash (
		.clk(clk),
		.rst(rst),
		.vadr(lat_vadr),
		.asid(lat_asid),
		.bounce(bounce),
		.probe_valid(probe_valid),
		.home_group(),
		.probe_group(probe_group)
	);

	ht_group_table #(
		.groups_log2(groups_log2)
	) u_table (
		.clk(clk),
		.wr_en(wr_en),
		.wr_group(wr_group),
		.wr_slot(wr_slot),
		.wr_data(wr_data),
		.rd_group_idx(probe_group),
		.rd_group(rd_group)
	);

	ht_walker #(
		.max_bounce(max_bounce)
	) u_walker (
		.clk(clk),
		.rst(rst),
		.req(req),
		.vadr(vadr),
		.asid(asid),
		.ack(ack),
		.hit(hit),
		.ppn(ppn),
		.bounce(bounce),
		.probe_valid(probe_valid),
		.lat_vadr(lat_vadr),
		.lat_asid(lat_asid),
		.rd_group(rd_group)
	);

endmodule

`default_nettype wire

// ==== sim/ht_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ht_tb;
	import ht_pkg::*;

	localparam int wait_limit = 500;
	localparam int bounce_limit = 40;
	// Filler entries carry the requested page under a space that no translation asks for
	localparam logic [asid_w-1:0] filler_asid = 10'h3ff;

	logic clk = 1'b0;
	logic rst;
	logic req;
	logic [vadr_w-1:0] vadr;
	logic [asid_w-1:0] asid;
	logic ack;
	logic hit;
	logic [ppn_w-1:0] ppn;
	logic wr_en;
	logic [group_w-1:0] wr_group;
	logic [2:0] wr_slot;
	ht_pte_u wr_data;

	logic [31:0] lfsr = 32'h0dfbbbd4;
	int trans_count = 0;

	ht_top #(
		.max_bounce(bounce_limit),
		.groups_log2(group_w)
	) uut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.vadr(vadr),
		.asid(asid),
		.ack(ack),
		.hit(hit),
		.ppn(ppn),
		.wr_en(wr_en),
		.wr_group(wr_group),
		.wr_slot(wr_slot),
		.wr_data(wr_data)
	);

	always #5 clk = ~clk;

	// ==================================================================
	// Reporting and random gaps
	// ==================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s hit expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_ppn(input string name, input logic [ppn_w-1:0] exp,
		input logic [ppn_w-1:0] act);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s ppn expected %05h actual %05h", name, exp, act));
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit, three bits give a gap of 0 to 7 cycles
	task automatic draw_gap(output logic [2:0] gap);
		gap = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			gap = {gap[1:0], lfsr[0]};
		end
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (ack !== level && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (ack !== level)
			abort_run($sformatf("Timeout after %0d cycles waiting for ack to %s",
				wait_limit, what));
	endtask

	// ==================================================================
	// Table loading
	// ==================================================================

	task automatic load_entry(input logic [group_w-1:0] g, input logic [2:0] s,
		input logic [pte_w-1:0] raw);
		@(negedge clk);
		wr_en = 1'b1;
		wr_group = g;
		wr_slot = s;
		wr_data.raw = raw;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	// The memories power up unknown, so every slot is written invalid first
	task automatic clear_table();
		for (int g = 0; g < (1 << group_w); g++) begin
			for (int s = 0; s < slots; s++)
				load_entry(group_w'(g), 3'(s), '0);
		end
	endtask

	// Home group is the two page number halves and the asid folded by XOR
	function automatic logic [group_w-1:0] expected_home(input logic [vadr_w-1:0] va,
		input logic [asid_w-1:0] as);
		logic [19:0] page;
		page = va[31:12];
		return page[9:0] ^ page[19:10] ^ as;
	endfunction

	// Fills every slot of the first count groups a translation will probe
	task automatic fill_probes(input logic [vadr_w-1:0] va, input logic [asid_w-1:0] as,
		input int count);
		logic [group_w-1:0] home;
		logic [group_w-1:0] g;
		logic [pte_w-1:0] filler;
		home = expected_home(va, as);
		g = home;
		for (int k = 0; k < count; k++) begin
			// Quadratic offsets k*k+1 up to bounce 31, then one group per probe
			if (k == 0)
				g = home;
			else if (k < 32)
				g = home + group_w'(k * k) + group_w'(1);
			else
				g = g + group_w'(1);
			for (int s = 0; s < slots; s++) begin
				filler = {13'd0, 1'b1, filler_asid, va[vadr_w-1:vadr_w-vpn_w], 10'd0, g};
				load_entry(g, 3'(s), filler);
			end
		end
	endtask

	// ==================================================================
	// One translation with the four-phase handshake
	// ==================================================================

	task automatic translate(input string name, input logic [vadr_w-1:0] va,
		input logic [asid_w-1:0] as, input logic exp_hit, input logic [ppn_w-1:0] exp_ppn);
		logic [2:0] gap;
		draw_gap(gap);
		repeat (gap) @(negedge clk);
		@(negedge clk);
		if (ack !== 1'b0)
			abort_run($sformatf("%s found ack still high before raising req", name));
		req = 1'b1;
		vadr = va;
		asid = as;
		@(negedge clk);
		wait_ack(1'b1, "rise");
		check_hit(name, exp_hit, hit);
		check_ppn(name, exp_ppn, ppn);
		// Holding req must keep the result frozen
		draw_gap(gap);
		repeat (gap) begin
			@(negedge clk);
			if (ack !== 1'b1)
				abort_run($sformatf("%s saw ack fall while req was still high", name));
			check_hit(name, exp_hit, hit);
			check_ppn(name, exp_ppn, ppn);
		end
		req = 1'b0;
		wait_ack(1'b0, "fall");
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================

	initial begin
		int fd;
		int got;
		string line;
		byte kind;
		logic [63:0] f0;
		logic [63:0] f1;
		logic [63:0] f2;
		logic [63:0] f3;
		rst = 1'b1;
		req = 1'b0;
		vadr = '0;
		asid = '0;
		wr_en = 1'b0;
		wr_group = '0;
		wr_slot = '0;
		wr_data = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		if (ack !== 1'b0)
			abort_run("ack was not low after reset");
		check_hit("reset", 1'b0, hit);
		check_ppn("reset", '0, ppn);
		clear_table();
		fd = $fopen("sim/ht_trace.txt", "r");
		if (fd == 0)
			abort_run("Could not open the trace file sim/ht_trace.txt");
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 1) begin
				kind = line.getc(0);
				case (kind)
					"L": begin
						if ($sscanf(line, "L %h %h %h", f0, f1, f2) != 3)
							abort_run($sformatf("Malformed load record %s", line));
						load_entry(f0[group_w-1:0], f1[2:0], f2);
					end
					"P": begin
						// The probe count is written in decimal
						if ($sscanf(line, "P %h %h %d", f0, f1, f2) != 3)
							abort_run($sformatf("Malformed fill record %s", line));
						fill_probes(f0[vadr_w-1:0], f1[asid_w-1:0], int'(f2[15:0]));
					end
					"T": begin
						if ($sscanf(line, "T %h %h %h %h", f0, f1, f2, f3) != 4)
							abort_run($sformatf("Malformed translate record %s", line));
						trans_count++;
						translate($sformatf("translate %0d", trans_count), f0[vadr_w-1:0],
							f1[asid_w-1:0], f2[0], f3[ppn_w-1:0]);
					end
					"#": begin
						// Column notes at the top of the trace
					end
					default: abort_run($sformatf("Unknown record in trace %s", line));
				endcase
			end
		end
		$fclose(fd);
		if (trans_count == 0)
			abort_run("The trace held no translate records");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/ht_pkg.sv
verilog/ht_hash.sv
verilog/ht_group_table.sv
verilog/ht_walker.sv
verilog/ht_top.sv
sim/ht_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ht_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TRACE ?= sim/ht_trace.txt
VFLAGS ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

check: run
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/ht_trace.txt ====
# L group slot raw_word loads one entry, P vadr asid count fills the first count probe groups
# T vadr asid hit ppn translates and compares the expected hit flag and physical page number
L 30c 0 00040112345abcde
T 12345000 001 1 abcde
T 12345000 002 0 00000
L 30c 3 0004011234555555
T 12345000 001 1 abcde
T 0030d000 001 0 00000
L 30c 7 0004010030d0f0f0
T 0030d000 001 1 0f0f0
P 00100000 005 1
L 107 0 0004050010011111
T 00100000 005 1 11111
P 00040000 007 34
L 00c 0 0004070004022222
T 00040000 007 1 22222
P 00040000 007 41
L 013 0 0004070004033333
T 00040000 007 0 00000
